// File: Makefile
SIM_TOOL  = verilator
SIM_FLAGS = --binary --assert --timing -j 0
TOP       = fetch_tb
FILE_LIST = compile.f
LOG       = sim.log
FAIL_MSG  = Something failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   list targets"

test:
	$(SIM_TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
+incdir+hw
hw/fetch_pkg.sv
hw/pc_reg.sv
hw/branch_predictor.sv
hw/inst_mem.sv
hw/fetch_top.sv
dv/tb_clock.sv
dv/fetch_props.sv
dv/fetch_tb.sv

// File: dv/fetch_props.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_props import fetch_pkg::*; (
  input logic                 clk,
  input logic                 reset_i,
  input logic                 stall_i,
  input logic                 flush_i,
  input logic                 trap_valid_i,
  input logic [`XLEN-1:0]     trap_pc_i,
  input logic                 redirect_valid_i,
  input logic [`XLEN-1:0]     redirect_pc_i,
  input logic                 psel_i,
  input logic [`INST_LEN-1:0] inst_o,
  input logic [`XLEN-1:0]     inst_pc_o,
  input logic                 inst_valid_o,
  input pc_src_e              pc_src_i
);

  localparam logic [`XLEN-1:0] PATTERN = 32'h5A5A_0000; // memory fill key

  logic [`XLEN-1:0] word_addr; // fetch address after wrap
  logic             quiet;     // nothing that could disturb a held fetch

  assign word_addr = {{(`XLEN-`IMEM_AW-2){1'b0}}, inst_pc_o[`IMEM_AW+1:2], 2'b00};
  assign quiet     = !psel_i && !trap_valid_i && !redirect_valid_i && !flush_i && !reset_i;

  a_inst_data: assert property (@(posedge clk) disable iff (reset_i)
    inst_valid_o |-> inst_o == (word_addr ^ PATTERN))
    else $error("inst_o does not hold the word at inst_pc_o");

  a_stall_invalid: assert property (@(posedge clk) disable iff (reset_i)
    stall_i |-> !inst_valid_o)
    else $error("inst_valid_o high during stall");

  // held fetch, two quiet stalled cycles behind us
  a_stall_hold: assert property (@(posedge clk) disable iff (reset_i)
    stall_i && $past(stall_i && quiet) && $past(stall_i && quiet, 2)
      |-> $stable(inst_o) && $stable(inst_pc_o))
    else $error("fetch output moved during stall");

  a_reset_bubble: assert property (@(posedge clk)
    $fell(reset_i) |-> !inst_valid_o)
    else $error("inst_valid_o high in first cycle after reset");

  a_flush_restart: assert property (@(posedge clk) disable iff (reset_i)
    flush_i |=> !inst_valid_o && inst_pc_o == `PC_RESET_ADDR)
    else $error("flush did not restart at reset address");

  a_trap_target: assert property (@(posedge clk) disable iff (reset_i)
    trap_valid_i && !stall_i && !flush_i |=> inst_pc_o == $past(trap_pc_i))
    else $error("trap target not taken");

  a_redirect_target: assert property (@(posedge clk) disable iff (reset_i)
    redirect_valid_i && !trap_valid_i && !stall_i && !flush_i
      |=> inst_pc_o == $past(redirect_pc_i))
    else $error("redirect target not taken");

  a_seq_step: assert property (@(posedge clk) disable iff (reset_i)
    inst_valid_o && pc_src_i == PC_SEQ && !flush_i |=> inst_pc_o == $past(inst_pc_o) + 4)
    else $error("sequential fetch did not step by 4");

endmodule

bind fetch_top fetch_props u_props (
  .clk              (clk),
  .reset_i          (reset_i),
  .stall_i          (stall_i),
  .flush_i          (flush_i),
  .trap_valid_i     (trap_valid_i),
  .trap_pc_i        (trap_pc_i),
  .redirect_valid_i (redirect_valid_i),
  .redirect_pc_i    (redirect_pc_i),
  .psel_i           (psel_i),
  .inst_o           (inst_o),
  .inst_pc_o        (inst_pc_o),
  .inst_valid_o     (inst_valid_o),
  .pc_src_i         (pc_src)
);

// File: dv/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_tb import fetch_pkg::*; ();

  localparam logic [31:0] PATTERN = 32'h5A5A_0000;
  localparam int WAIT_LIMIT = 32; // cycles per wait loop

  logic clk, reset_i, stall_i, flush_i;
  logic trap_valid_i, redirect_valid_i;
  logic [31:0] trap_pc_i, redirect_pc_i;
  logic resolve_valid_i, resolve_taken_i;
  logic [31:0] resolve_pc_i, resolve_target_i;
  logic psel_i, penable_i, pwrite_i;
  logic [31:0] paddr_i, pwdata_i, prdata_o, inst_o, inst_pc_o;
  logic pready_o, pslverr_o, inst_valid_o;
  int errors, tests, errors_before, n, idx;
  logic [31:0] rdata, pc_a, pc_b, inst, tgt_p, tgt_t;
  logic slverr;

  tb_clock u_clock (.clk(clk), .reset_o(reset_i));

  fetch_top i_dut (.*);

  task check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("error %s got %h expected %h", name, got, exp);
    end
  endtask

  task check_true(input string what, input logic cond);
    assert (cond === 1'b1) else begin
      errors++;
      $display("check failed: %s", what);
    end
  endtask

  task end_test(input string name);
    tests++;
    $display("test %s finished with %0d errors", name, errors - errors_before);
    errors_before = errors;
  endtask

  function automatic logic [31:0] rand_addr(); // word aligned, room for a few steps
    return ($urandom % 192) << 2;
  endfunction

  task apb_access(input apb_kind_e kind, input logic [31:0] addr, input logic [31:0] wdata,
                  output logic [31:0] data, output logic err);
    int cnt;
    @(negedge clk); // setup phase
    psel_i = 1'b1;
    penable_i = 1'b0;
    pwrite_i = (kind == APB_WRITE);
    paddr_i = addr;
    pwdata_i = wdata;
    @(negedge clk);
    penable_i = 1'b1;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (!pready_o && cnt < WAIT_LIMIT);
    if (!pready_o) begin
      errors++;
      $display("timeout waiting for pready_o");
    end
    data = prdata_o;
    err = pslverr_o;
    @(negedge clk);
    psel_i = 1'b0;
    penable_i = 1'b0;
  endtask

  // look at the current cycle first when check_now is set
  task next_valid(input logic check_now, output logic [31:0] pc, output logic [31:0] word);
    int cnt;
    cnt = 0;
    if (!check_now) @(negedge clk);
    while (!inst_valid_o && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!inst_valid_o) begin
      errors++;
      $display("timeout waiting for inst_valid_o");
    end
    pc = inst_pc_o;
    word = inst_o;
  endtask

  task jump_to(input logic trap, input logic [31:0] tpc, input logic redir,
               input logic [31:0] rpc);
    @(negedge clk);
    trap_valid_i = trap;
    trap_pc_i = tpc;
    redirect_valid_i = redir;
    redirect_pc_i = rpc;
    @(negedge clk); // target is on pc now
    trap_valid_i = 1'b0;
    redirect_valid_i = 1'b0;
  endtask

  task resolve(input logic [31:0] pc, input logic [31:0] target, input logic taken);
    @(negedge clk);
    resolve_valid_i = 1'b1;
    resolve_pc_i = pc;
    resolve_target_i = target;
    resolve_taken_i = taken;
    @(negedge clk);
    resolve_valid_i = 1'b0;
  endtask

  initial begin
    stall_i = 1'b0; // fetch runs through reset release, first-cycle bubble visible
    flush_i = 1'b0;
    trap_valid_i = 1'b0;
    trap_pc_i = '0;
    redirect_valid_i = 1'b0;
    redirect_pc_i = '0;
    resolve_valid_i = 1'b0;
    resolve_pc_i = '0;
    resolve_target_i = '0;
    resolve_taken_i = 1'b0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    errors = 0;
    tests = 0;
    errors_before = 0;
    n = $urandom(32'haa99e556);
    n = 0;
    while (reset_i !== 1'b0 && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    check_true("reset released in time", reset_i === 1'b0);
    @(negedge clk);
    stall_i = 1'b1; // fetch frozen until memory is loaded

    // apb load and readback
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      apb_access(APB_WRITE, i << 2, (i << 2) ^ PATTERN, rdata, slverr);
      check_true("no pslverr_o on in-range write", !slverr);
    end
    for (int i = 0; i < 16; i++) begin
      idx = $urandom % `IMEM_WORDS;
      apb_access(APB_READ, idx << 2, '0, rdata, slverr);
      check_eq("prdata_o", rdata, (idx << 2) ^ PATTERN);
    end
    apb_access(APB_READ, `IMEM_WORDS * 4, '0, rdata, slverr);
    check_true("pslverr_o on out-of-range read", slverr);
    check_eq("prdata_o", rdata, '0);
    end_test("apb_round_trip");

    // sequential run from the reset address
    @(negedge clk);
    stall_i = 1'b0;
    #1; // inst_valid_o follows stall_i
    next_valid(1'b1, pc_a, inst);
    check_eq("inst_pc_o", pc_a, `PC_RESET_ADDR);
    for (int i = 0; i < 16; i++) begin
      next_valid(1'b0, pc_b, inst);
      check_eq("inst_pc_o", pc_b, pc_a + 4);
      pc_a = pc_b;
    end
    end_test("sequential");

    // trap beats redirect
    tgt_p = rand_addr();
    tgt_t = rand_addr();
    if (tgt_p == tgt_t) tgt_p = tgt_t + 8;
    jump_to(1'b1, tgt_t, 1'b1, tgt_p);
    next_valid(1'b1, pc_a, inst);
    check_eq("inst_pc_o", pc_a, tgt_t);
    tgt_p = rand_addr();
    jump_to(1'b0, '0, 1'b1, tgt_p);
    next_valid(1'b1, pc_a, inst);
    check_eq("inst_pc_o", pc_a, tgt_p);
    end_test("redirect_priority");

    // taken branch installed in btb, then dropped
    tgt_p = rand_addr();
    tgt_t = rand_addr();
    if (tgt_t == tgt_p || tgt_t == tgt_p + 4) tgt_t = tgt_p + 8;
    resolve(tgt_p, tgt_t, 1'b1);
    jump_to(1'b0, '0, 1'b1, tgt_p);
    next_valid(1'b1, pc_a, inst);
    check_eq("inst_pc_o", pc_a, tgt_p);
    next_valid(1'b0, pc_b, inst);
    check_eq("inst_pc_o", pc_b, tgt_t); // predicted, no redirect
    resolve(tgt_p, tgt_t, 1'b0);
    jump_to(1'b0, '0, 1'b1, tgt_p);
    next_valid(1'b1, pc_a, inst);
    check_eq("inst_pc_o", pc_a, tgt_p);
    next_valid(1'b0, pc_b, inst);
    check_eq("inst_pc_o", pc_b, tgt_p + 4);
    end_test("prediction");

    // stall holds, flush restarts
    next_valid(1'b1, pc_a, inst);
    stall_i = 1'b1;
    repeat (5) begin
      @(negedge clk);
      check_true("inst_valid_o low while stalled", !inst_valid_o);
      check_eq("inst_pc_o", inst_pc_o, pc_a);
      check_eq("inst_o", inst_o, pc_a ^ PATTERN);
    end
    stall_i = 1'b0;
    #1; // inst_valid_o follows stall_i
    next_valid(1'b1, pc_b, inst);
    check_eq("inst_pc_o", pc_b, pc_a);
    check_eq("inst_o", inst, pc_b ^ PATTERN); // held word not lost
    @(negedge clk);
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    next_valid(1'b1, pc_a, inst);
    check_eq("inst_pc_o", pc_a, `PC_RESET_ADDR);
    end_test("stall_flush");

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset_o
);

  localparam time HALF_PERIOD = 50ns; // 100 ns clock

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // reset held over two rising edges, released on a falling edge
  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_o = 1'b0;
  end

endmodule

// File: hw/branch_predictor.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module branch_predictor (
  input  logic             clk,
  input  logic             reset_i,
  input  logic [`XLEN-1:0] lookup_pc_i,      // current fetch pc
  input  logic             resolve_valid_i,  // branch resolved in execute
  input  logic [`XLEN-1:0] resolve_pc_i,
  input  logic [`XLEN-1:0] resolve_target_i,
  input  logic             resolve_taken_i,
  output logic             bpu_valid_o,      // tag hit
  output logic [`XLEN-1:0] bpu_pc_o          // predicted target
);

  // btb storage, valid bits get reset, tag and target do not
  logic [`BTB_ENTRIES-1:0] valid_q;
  logic [`BTB_TAG_W-1:0]   tag_q    [`BTB_ENTRIES];
  logic [`XLEN-1:0]        target_q [`BTB_ENTRIES];

  logic [`BTB_IDX_W-1:0]   lookup_idx;
  logic [`BTB_TAG_W-1:0]   lookup_tag;
  logic [`BTB_IDX_W-1:0]   resolve_idx;
  logic [`BTB_TAG_W-1:0]   resolve_tag;

  // index just above the byte offset
  assign lookup_idx  = lookup_pc_i[`BTB_IDX_W+1:2];
  assign lookup_tag  = lookup_pc_i[`XLEN-1:`BTB_IDX_W+2];
  assign resolve_idx = resolve_pc_i[`BTB_IDX_W+1:2];
  assign resolve_tag = resolve_pc_i[`XLEN-1:`BTB_IDX_W+2];

  // zero cycle lookup
  always_comb begin
    bpu_valid_o = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    bpu_pc_o    = target_q[lookup_idx];
  end

  // valid bits
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= '0; // empty btb after reset
    end else if (resolve_valid_i) begin
      // taken installs, not taken drops the entry
      valid_q[resolve_idx] <= resolve_taken_i;
    end
  end

  // tag and target payload
  always_ff @(posedge clk) begin
    if (resolve_valid_i && resolve_taken_i) begin
      tag_q[resolve_idx]    <= resolve_tag;
      target_q[resolve_idx] <= resolve_target_i; // overwrites any alias
    end
  end

  // note: an update and a lookup of the same index in one cycle
  // see the old entry, the new one is visible after the edge
  // not-taken keeps the stale tag/target, valid bit masks them

endmodule

// File: hw/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// datapath widths
`define XLEN            32
`define INST_LEN        32 // no compressed instructions

// pc after reset and after a flush
`define PC_RESET_ADDR   32'h0000_0000

// instruction memory, word addressed
`define IMEM_WORDS      256 // byte range 0 .. 0x3fc
`define IMEM_AW         8   // word index width

// branch target buffer, direct mapped
`define BTB_ENTRIES     16
`define BTB_IDX_W       4
// tag is what is left above the index and the byte offset
`define BTB_TAG_W       (`XLEN - `BTB_IDX_W - 2)

`endif

// File: hw/fetch_pkg.sv
package fetch_pkg;

  // source of the next fetch address
  // encoded low to high priority, trap wins
  typedef enum logic [1:0] {
    PC_SEQ    = 2'd0, // pc + 4, or refetch of pc after reset/flush
    PC_BPU    = 2'd1, // btb hit on the current pc
    PC_BRANCH = 2'd2, // redirect from execute
    PC_TRAP   = 2'd3  // trap target from the csr side
  } pc_src_e;

  // kind of apb transfer seen in the access phase
  typedef enum logic [1:0] {
    APB_IDLE  = 2'd0, // no access phase this cycle
    APB_READ  = 2'd1,
    APB_WRITE = 2'd2
  } apb_kind_e;

  // setup phase decodes as idle
  // the memory acts on the access phase only

endpackage

// File: hw/fetch_top.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_top import fetch_pkg::*; (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 stall_i,
  input  logic                 flush_i,
  input  logic                 trap_valid_i,
  input  logic [`XLEN-1:0]     trap_pc_i,
  input  logic                 redirect_valid_i,
  input  logic [`XLEN-1:0]     redirect_pc_i,
  input  logic                 resolve_valid_i,
  input  logic [`XLEN-1:0]     resolve_pc_i,
  input  logic [`XLEN-1:0]     resolve_target_i,
  input  logic                 resolve_taken_i,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  logic [`XLEN-1:0]     paddr_i,
  input  logic [`XLEN-1:0]     pwdata_i,
  output logic [`INST_LEN-1:0] inst_o,
  output logic [`XLEN-1:0]     inst_pc_o,     // pc of inst_o
  output logic                 inst_valid_o,
  output logic [`XLEN-1:0]     prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o
);

  logic [`XLEN-1:0] pc_next;  // imem read address
  pc_src_e          pc_src;   // observed by the bound checks
  logic             bpu_valid;
  logic [`XLEN-1:0] bpu_pc;

  pc_reg u_pc_reg (
    .clk              (clk),
    .reset_i          (reset_i),
    .stall_i          (stall_i),
    .flush_i          (flush_i),
    .trap_valid_i     (trap_valid_i),
    .trap_pc_i        (trap_pc_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .bpu_valid_i      (bpu_valid),
    .bpu_pc_i         (bpu_pc),
    .pc_next_o        (pc_next),
    .pc_o             (inst_pc_o),
    .pc_src_o         (pc_src),
    .fetch_valid_o    (inst_valid_o)
  );

  // predictor looks up the registered pc
  branch_predictor u_bpu (
    .clk (clk), .reset_i (reset_i), .lookup_pc_i (inst_pc_o),
    .resolve_valid_i (resolve_valid_i), .resolve_pc_i (resolve_pc_i),
    .resolve_target_i (resolve_target_i), .resolve_taken_i (resolve_taken_i),
    .bpu_valid_o (bpu_valid), .bpu_pc_o (bpu_pc)
  );

  inst_mem u_imem (
    .clk (clk), .reset_i (reset_i), .fetch_addr_i (pc_next),
    .psel_i (psel_i), .penable_i (penable_i), .pwrite_i (pwrite_i),
    .paddr_i (paddr_i), .pwdata_i (pwdata_i), .inst_o (inst_o),
    .prdata_o (prdata_o), .pready_o (pready_o), .pslverr_o (pslverr_o)
  );

endmodule

// File: hw/inst_mem.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module inst_mem import fetch_pkg::*; (
  input  logic                clk,
  input  logic                reset_i,
  input  logic [`XLEN-1:0]    fetch_addr_i, // byte address, wraps
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  logic [`XLEN-1:0]    paddr_i,
  input  logic [`XLEN-1:0]    pwdata_i,
  output logic [`INST_LEN-1:0] inst_o,      // one cycle after fetch_addr_i
  output logic [`XLEN-1:0]    prdata_o,
  output logic                pready_o,
  output logic                pslverr_o
);

  logic [`INST_LEN-1:0] mem_q [`IMEM_WORDS]; // word array
  logic [`INST_LEN-1:0] inst_q;

  apb_kind_e            apb_kind;
  logic [`IMEM_AW-1:0]  fetch_idx;
  logic [`IMEM_AW-1:0]  apb_idx;
  logic                 apb_in_range;
  logic                 apb_wr_en;

  // fetch address modulo memory size
  assign fetch_idx = fetch_addr_i[`IMEM_AW+1:2];
  assign apb_idx   = paddr_i[`IMEM_AW+1:2];

  // anything above IMEM_WORDS*4 is out of range
  assign apb_in_range = (paddr_i[`XLEN-1:`IMEM_AW+2] == '0);

  // access phase decode, setup phase is idle
  always_comb begin
    apb_kind = APB_IDLE;
    if (psel_i && penable_i) begin
      apb_kind = pwrite_i ? APB_WRITE : APB_READ;
    end
  end

  // no host writes while the core is held in reset
  assign apb_wr_en = (apb_kind == APB_WRITE) && apb_in_range && !reset_i;

  // write lands on the access phase edge
  always_ff @(posedge clk) begin
    if (apb_wr_en) begin
      mem_q[apb_idx] <= pwdata_i;
    end
  end

  // registered fetch read, same cycle write gives old word
  always_ff @(posedge clk) begin
    inst_q <= mem_q[fetch_idx];
  end

  assign inst_o = inst_q;

  // zero wait slave
  assign pready_o  = psel_i & penable_i; // high every access phase
  assign pslverr_o = (apb_kind != APB_IDLE) && !apb_in_range;

  // read data straight from the array, zero when out of range
  always_comb begin
    prdata_o = '0;
    if (apb_kind == APB_READ && apb_in_range) begin
      prdata_o = mem_q[apb_idx];
    end
  end

endmodule

// File: hw/pc_reg.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module pc_reg import fetch_pkg::*; (
  input  logic             clk,
  input  logic             reset_i,
  input  logic             stall_i,
  input  logic             flush_i,
  input  logic             trap_valid_i,     // highest priority
  input  logic [`XLEN-1:0] trap_pc_i,
  input  logic             redirect_valid_i, // branch redirect
  input  logic [`XLEN-1:0] redirect_pc_i,
  input  logic             bpu_valid_i,      // btb hit on pc_o
  input  logic [`XLEN-1:0] bpu_pc_i,
  output logic [`XLEN-1:0] pc_next_o,        // imem read address
  output logic [`XLEN-1:0] pc_o,             // address of inst on imem output
  output pc_src_e          pc_src_o,
  output logic             fetch_valid_o
);

  localparam logic [`XLEN-1:0] PC_STEP = `XLEN'(4);

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] pc_sel;
  logic             primed_q; // pc_q has been presented to imem
  logic             jump;

  assign jump = trap_valid_i | redirect_valid_i;

  // fixed priority next-pc select
  always_comb begin
    if (trap_valid_i) begin
      pc_sel   = trap_pc_i;
      pc_src_o = PC_TRAP;
    end else if (redirect_valid_i) begin
      pc_sel   = redirect_pc_i;
      pc_src_o = PC_BRANCH;
    end else if (!primed_q) begin
      pc_sel   = pc_q; // after reset/flush pc_q itself is fetched first
      pc_src_o = PC_SEQ;
    end else if (bpu_valid_i) begin
      pc_sel   = bpu_pc_i;
      pc_src_o = PC_BPU;
    end else begin
      pc_sel   = pc_q + PC_STEP;
      pc_src_o = PC_SEQ;
    end
  end

  // redirect and trap reach imem even during a stall
  assign pc_next_o = jump    ? pc_sel :
                     stall_i ? pc_q :
                     flush_i ? `PC_RESET_ADDR : pc_sel;

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      pc_q     <= `PC_RESET_ADDR;
      primed_q <= 1'b0; // one bubble, imem latency
    end else if (stall_i) begin
      if (jump) primed_q <= 1'b0; // imem now holds the target word, refetch pc_q
    end else begin
      pc_q     <= pc_sel;
      primed_q <= 1'b1;
    end
  end

  assign pc_o          = pc_q;
  assign fetch_valid_o = primed_q & ~stall_i; // held inst is not consumed while stalled

endmodule
